/* spi_reg_bridge.f */
spi_pkg.sv
spi_slave.sv
spi_cmd_decoder.sv
reg_bank.sv
spi_reg_bridge.sv
tb_spi_reg_bridge.sv

/* Makefile */
# Verilator build and run for the SPI register bridge testbench

TOP  = tb_spi_reg_bridge
SRCS = $(shell cat spi_reg_bridge.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): spi_reg_bridge.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f spi_reg_bridge.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_spi_reg_bridge.sv */
/*
  Testbench for the SPI register bridge. A bit-banged mode 0 master runs
  write and read frames, and a register model predicts reg_out and the
  bytes returned on miso.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_spi_reg_bridge;

  localparam int NUM_REGS   = 8;
  localparam int CLK_PERIOD = 8;
  localparam int HALF_CYC   = 5;
  localparam int GAP_CYC    = 8;
  localparam int MAX_BYTES  = 12;
  localparam int NUM_RANDOM = 40;
  localparam int NUM_FRAMES = 5 + NUM_RANDOM;
  localparam int FRAME_CYC  = MAX_BYTES * 16 * HALF_CYC + 2 * HALF_CYC + GAP_CYC + 4;
  localparam int TIMEOUT_NS = (NUM_FRAMES * FRAME_CYC + 200) * CLK_PERIOD;

  localparam logic [1:0] KIND_RX   = 2'd0;
  localparam logic [1:0] KIND_REG  = 2'd1;
  localparam logic [1:0] KIND_MISO = 2'd2;

  // One pending comparison
  typedef struct packed {
    logic [1:0]         kind;
    logic [7:0]         index;
    spi_pkg::spi_byte_t got;
    spi_pkg::spi_byte_t exp;
  } check_t;

  logic clk;
  logic rst;
  logic sck;
  logic ss;
  logic mosi;
  logic miso;
  spi_pkg::spi_byte_t [NUM_REGS-1:0] reg_out;

  spi_pkg::spi_byte_t model   [NUM_REGS];
  spi_pkg::spi_byte_t tx_buf  [MAX_BYTES];
  spi_pkg::spi_byte_t rx_buf  [MAX_BYTES];
  spi_pkg::spi_byte_t exp_buf [MAX_BYTES];
  check_t             chk_q   [$];
  logic [31:0]        seed;
  int                 total_checks;
  int                 total_errors;
  int                 test_checks;
  int                 test_errors;

  spi_reg_bridge #(
    .NUM_REGS (NUM_REGS)
  ) spi_reg_bridge_inst (
    .clk     (clk),
    .rst     (rst),
    .sck     (sck),
    .ss      (ss),
    .mosi    (mosi),
    .miso    (miso),
    .reg_out (reg_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Register model that applies one frame and fills exp_buf with the miso bytes
  function automatic void ref_frame(input logic write, input int start, input int n);
    int a;
    exp_buf[0] = 8'h00;
    for (int k = 1; k < n; k++) begin
      if (write) begin
        a = start + k - 1;
        // Register 0 and addresses past the bank are not writable
        if (a >= 1 && a < NUM_REGS) begin
          model[a] = tx_buf[k];
        end
        exp_buf[k] = 8'h00;
      end else if (k == 1) begin
        exp_buf[k] = 8'h00;
      end else begin
        a = start + k - 2;
        exp_buf[k] = (a < NUM_REGS) ? model[a] : 8'h00;
      end
    end
  endfunction

  function automatic string describe(input check_t c);
    case (c.kind)
      KIND_RX:  return $sformatf("miso byte %0d", c.index);
      KIND_REG: return $sformatf("reg_out[%0d]", c.index);
      default:  return "miso level in reset";
    endcase
  endfunction

  // Drains pending checks on each clock
  initial begin
    check_t c;
    forever begin
      @(posedge clk);
      while (chk_q.size() != 0) begin
        c = chk_q.pop_front();
        total_checks++;
        assert (c.got === c.exp) else begin
          total_errors++;
          $display("mismatch at %0d ns: %s got %02h expected %02h",
                   $time, describe(c), c.got, c.exp);
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: tests did not complete within %0d ns", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic queue_check(input logic [1:0] kind, input int idx,
                             input spi_pkg::spi_byte_t got, input spi_pkg::spi_byte_t exp);
    check_t c;
    c.kind  = kind;
    c.index = idx[7:0];
    c.got   = got;
    c.exp   = exp;
    chk_q.push_back(c);
  endtask

  task automatic check_regs();
    for (int i = 0; i < NUM_REGS; i++) begin
      queue_check(KIND_REG, i, reg_out[i], model[i]);
    end
  endtask

  // Bit-banged mode 0 master that sends tx_buf and collects rx_buf
  task automatic spi_frame(input int n);
    spi_pkg::spi_byte_t rx;
    ss = 1'b0;
    for (int b = 0; b < n; b++) begin
      for (int i = 7; i >= 0; i--) begin
        mosi = tx_buf[b][i];
        wait_clks(HALF_CYC);
        rx[i] = miso;
        sck = 1'b1;
        wait_clks(HALF_CYC);
        sck = 1'b0;
      end
      rx_buf[b] = rx;
    end
    wait_clks(HALF_CYC);
    ss   = 1'b1;
    mosi = 1'b0;
    // Let the last write land and the idle byte reload
    wait_clks(GAP_CYC);
  endtask

  task automatic run_frame(input logic write, input int start, input int n);
    spi_pkg::cmd_t cmd;
    cmd.write = write;
    cmd.addr  = spi_pkg::reg_addr_t'(start);
    tx_buf[0] = cmd;
    spi_frame(n);
    ref_frame(write, start, n);
    for (int k = 0; k < n; k++) begin
      queue_check(KIND_RX, k, rx_buf[k], exp_buf[k]);
    end
    check_regs();
  endtask

  task automatic finish_test(input string name);
    wait_clks(2);
    $display("test %s: %0d checks, %0d errors, decoder %s", name,
             total_checks - test_checks, total_errors - test_errors,
             spi_reg_bridge_inst.spi_cmd_decoder_inst.state.name());
    test_checks = total_checks;
    test_errors = total_errors;
  endtask

  initial begin
    int start;
    int n;
    logic write;
    rst          = 1'b1;
    sck          = 1'b0;
    ss           = 1'b1;
    mosi         = 1'b0;
    seed         = 32'h1de1;
    total_checks = 0;
    total_errors = 0;
    test_checks  = 0;
    test_errors  = 0;
    model[0]     = spi_pkg::ID_VALUE;
    for (int i = 1; i < NUM_REGS; i++) begin
      model[i] = 8'h00;
    end

    repeat (8) @(posedge clk);
    #1;
    queue_check(KIND_MISO, 0, {7'b0, miso}, 8'h01);
    rst = 1'b0;
    wait_clks(4);
    check_regs();
    finish_test("reset");

    tx_buf[1] = 8'hA5;
    run_frame(1'b1, 3, 2);
    finish_test("single write");

    // Runs past the end of the bank
    for (int k = 1; k < 11; k++) begin
      tx_buf[k] = 8'h10 + k[7:0];
    end
    run_frame(1'b1, 1, 11);
    tx_buf[1] = 8'hEE;
    tx_buf[2] = 8'hC3;
    tx_buf[3] = 8'h3C;
    run_frame(1'b1, 0, 4);
    finish_test("burst write");

    run_frame(1'b0, 0, MAX_BYTES);
    run_frame(1'b0, 100, 5);
    finish_test("read frame");

    for (int f = 0; f < NUM_RANDOM; f++) begin
      seed  = lcg_step(seed);
      write = seed[16];
      start = int'(seed[23:17]) % 12;
      n     = 1 + int'(seed[30:27]) % (MAX_BYTES - 1);
      for (int k = 1; k < n; k++) begin
        seed      = lcg_step(seed);
        tx_buf[k] = seed[23:16];
      end
      run_frame(write, start, n);
    end
    finish_test("random frames");

    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* spi_reg_bridge.sv */
/*
  SPI register bridge top level. An external SPI master reads and writes
  the register bank over a mode 0 link; the registers appear on reg_out.
*/
`timescale 1ns/100ps
`default_nettype none

module spi_reg_bridge #(
  parameter int NUM_REGS = 8
) (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         sck,
  input  wire logic                         ss,
  input  wire logic                         mosi,
  output logic                              miso,
  output spi_pkg::spi_byte_t [NUM_REGS-1:0] reg_out
);

  logic               done;
  logic               selected;
  spi_pkg::spi_byte_t dout;
  spi_pkg::spi_byte_t din;
  spi_pkg::reg_wr_t   wr;
  spi_pkg::reg_addr_t rd_addr;
  spi_pkg::spi_byte_t rd_data;

  spi_slave spi_slave_inst (
    .clk      (clk),
    .rst      (rst),
    .sck      (sck),
    .ss       (ss),
    .mosi     (mosi),
    .din      (din),
    .miso     (miso),
    .done     (done),
    .selected (selected),
    .dout     (dout)
  );

  spi_cmd_decoder #(
    .NUM_REGS (NUM_REGS)
  ) spi_cmd_decoder_inst (
    .clk      (clk),
    .rst      (rst),
    .done     (done),
    .selected (selected),
    .dout     (dout),
    .rd_data  (rd_data),
    .din      (din),
    .wr       (wr),
    .rd_addr  (rd_addr)
  );

  reg_bank #(
    .NUM_REGS (NUM_REGS)
  ) reg_bank_inst (
    .clk      (clk),
    .rst      (rst),
    .wr       (wr),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .reg_out  (reg_out)
  );

endmodule

`default_nettype wire

/* reg_bank.sv */
/*
  Bank of NUM_REGS byte registers seen by the fabric as parallel outputs.
  Register 0 is a read-only identification value; out of range accesses
  are dropped on write and read as zero.
*/
`timescale 1ns/100ps
`default_nettype none

module reg_bank #(
  parameter int NUM_REGS = 8
) (
  input  wire logic                              clk,
  input  wire logic                              rst,
  input  wire spi_pkg::reg_wr_t                  wr,
  input  wire spi_pkg::reg_addr_t                rd_addr,
  output spi_pkg::spi_byte_t                     rd_data,
  output spi_pkg::spi_byte_t [NUM_REGS-1:0]      reg_out
);

  spi_pkg::spi_byte_t regs [1:NUM_REGS-1];

  if (NUM_REGS < 2 || NUM_REGS > 128) begin : g_bad_size
    $error("reg_bank: NUM_REGS must lie between 2 and 128");
  end

  assign reg_out[0] = spi_pkg::ID_VALUE;

  // One flop byte per writable register
  for (genvar i = 1; i < NUM_REGS; i++) begin : g_reg
    always_ff @(posedge clk) begin
      if (rst) begin
        regs[i] <= '0;
      end else if (wr.en && wr.addr == spi_pkg::reg_addr_t'(i)) begin
        regs[i] <= wr.data;
      end
    end

    assign reg_out[i] = regs[i];
  end

  // Slice 0 covers the ID read
  always_comb begin
    if (int'(rd_addr) < NUM_REGS) begin
      rd_data = reg_out[rd_addr];
    end else begin
      rd_data = '0;
    end
  end

  // A write to the ID address leaves every register as it was
  a_id_write_ignored: assert property (@(posedge clk) disable iff (rst)
    wr.en && wr.addr == '0 |=> $stable(reg_out));

endmodule

`default_nettype wire

/* spi_cmd_decoder.sv */
/*
  Frame protocol for the register bridge. Byte 0 is the command, then either
  a stream of writes or a turnaround byte followed by read data.
  Drives register writes, the read address and the next byte to send.
*/
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_decoder #(
  parameter int NUM_REGS = 8
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               done,
  input  wire logic               selected,
  input  wire spi_pkg::spi_byte_t dout,
  input  wire spi_pkg::spi_byte_t rd_data,
  output spi_pkg::spi_byte_t      din,
  output spi_pkg::reg_wr_t        wr,
  output spi_pkg::reg_addr_t      rd_addr
);

  spi_pkg::dec_state_t state;
  spi_pkg::reg_addr_t  addr;
  spi_pkg::reg_addr_t  next_addr;
  spi_pkg::cmd_t       cmd;

  assign cmd     = spi_pkg::cmd_t'(dout);
  assign rd_addr = addr;

  // Stop counting once past the bank, so the address never wraps to 0
  always_comb begin
    next_addr = addr;
    if (int'(addr) < NUM_REGS && addr != '1) begin
      next_addr = addr + 7'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= spi_pkg::st_cmd;
      addr   <= '0;
      wr.en  <= 1'b0;
    end else begin
      wr.en <= 1'b0;
      if (!selected) begin
        state <= spi_pkg::st_cmd;
      end else if (done) begin
        case (state)
          spi_pkg::st_cmd: begin
            addr  <= cmd.addr;
            state <= cmd.write ? spi_pkg::st_write : spi_pkg::st_turn;
          end
          spi_pkg::st_write: begin
            wr.en   <= 1'b1;
            wr.addr <= addr;
            wr.data <= dout;
            addr    <= next_addr;
          end
          spi_pkg::st_turn: begin
            state <= spi_pkg::st_read;
            addr  <= next_addr;
          end
          default: begin
            addr <= next_addr;
          end
        endcase
      end
    end
  end

  // Next byte to send. The slave picks it up at the end of the current byte,
  // so the turnaround state already offers the start register
  always_comb begin
    case (state)
      spi_pkg::st_turn,
      spi_pkg::st_read: din = rd_data;
      default:          din = '0;
    endcase
  end

  // Strobe lands while the frame is still in write mode
  a_wr_in_write: assert property (@(posedge clk) disable iff (rst)
    wr.en |-> state == spi_pkg::st_write);

endmodule

`default_nettype wire

/* spi_slave.sv */
/*
  SPI mode 0 slave. Samples the raw pins with clk, shifts one byte per frame
  slot and pulses done with the received byte on dout. din is loaded as the
  next byte to send, and selected gives the synchronized frame level.
*/
`timescale 1ns/100ps
`default_nettype none

module spi_slave (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              sck,
  input  wire logic              ss,
  input  wire logic              mosi,
  input  wire spi_pkg::spi_byte_t din,
  output logic                   miso,
  output logic                   done,
  output logic                   selected,
  output spi_pkg::spi_byte_t     dout
);

  // Pin samples
  logic sck_q;
  logic sck_prev;
  logic ss_q;
  logic mosi_q;

  logic sck_rise;
  logic sck_fall;

  spi_pkg::spi_byte_t shift_q;
  spi_pkg::spi_byte_t shift_d;
  spi_pkg::spi_byte_t dout_d;
  logic [2:0]         bit_cnt_q;
  logic [2:0]         bit_cnt_d;
  logic               miso_d;
  logic               done_d;

  // One register stage on every pin, ss comes up deselected
  always_ff @(posedge clk) begin
    sck_q    <= sck;
    sck_prev <= sck_q;
    mosi_q   <= mosi;
    if (rst) begin
      ss_q <= 1'b1;
    end else begin
      ss_q <= ss;
    end
  end

  assign sck_rise = sck_q & ~sck_prev;
  assign sck_fall = ~sck_q & sck_prev;
  assign selected = ~ss_q;

  always_comb begin
    shift_d   = shift_q;
    bit_cnt_d = bit_cnt_q;
    miso_d    = miso;
    done_d    = 1'b0;
    dout_d    = dout;

    if (ss_q) begin
      // Idle: hold the next byte ready, MSB already on miso
      bit_cnt_d = '0;
      shift_d   = din;
      miso_d    = shift_q[7];
    end else if (sck_rise) begin
      bit_cnt_d = bit_cnt_q + 3'd1;
      shift_d   = {shift_q[6:0], mosi_q};
      if (bit_cnt_q == 3'd7) begin
        // Last bit of the byte
        dout_d  = {shift_q[6:0], mosi_q};
        done_d  = 1'b1;
        shift_d = din;
      end
    end else if (sck_fall) begin
      miso_d = shift_q[7];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt_q <= '0;
      miso      <= 1'b1;
      done      <= 1'b0;
      dout      <= '0;
    end else begin
      bit_cnt_q <= bit_cnt_d;
      miso      <= miso_d;
      done      <= done_d;
      dout      <= dout_d;
    end
    shift_q <= shift_d;
  end

  // A received byte is a single pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

  // Bytes only arrive inside a frame
  a_done_in_frame: assert property (@(posedge clk) disable iff (rst) done |-> selected);

endmodule

`default_nettype wire

/* spi_pkg.sv */
/*
  Shared types and constants for the SPI register bridge.
  Modules refer to these by scoped name.
*/
`default_nettype none

package spi_pkg;

  // One byte on the serial link or in a register
  typedef logic [7:0] spi_byte_t;

  // Register address as carried in the command byte
  typedef logic [6:0] reg_addr_t;

  // Decoded command byte, bit 7 is the write flag
  typedef struct packed {
    logic      write;
    reg_addr_t addr;
  } cmd_t;

  // Register write from the decoder to the bank
  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    spi_byte_t data;
  } reg_wr_t;

  // Identification value returned by register 0
  localparam spi_byte_t ID_VALUE = 8'h5A;

  // Decoder frame states
  typedef enum logic [1:0] {
    st_cmd,
    st_turn,
    st_write,
    st_read
  } dec_state_t;

endpackage

`default_nettype wire
